//--- Bender.yml
package:
  name: fetch_decode

sources:
  - verilog/rv_fetch_pkg.sv
  - verilog/imm_gen.sv
  - verilog/pc_unit.sv
  - verilog/fetch_ctrl.sv
  - verilog/instr_decoder.sv
  - verilog/fetch_decode_top.sv
  - target: test
    files:
      - verif/fetch_decode_checker.sv
      - verif/fetch_decode_monitor.sv
      - verif/tb_fetch_decode.sv

//--- sources.f
verilog/rv_fetch_pkg.sv
verilog/imm_gen.sv
verilog/pc_unit.sv
verilog/fetch_ctrl.sv
verilog/instr_decoder.sv
verilog/fetch_decode_top.sv
verif/fetch_decode_checker.sv
verif/fetch_decode_monitor.sv
verif/tb_fetch_decode.sv

//--- verif/fetch_decode_checker.sv
`timescale 1ns/1ps

module fetch_decode_checker
  import rv_fetch_pkg::*;
(
  input logic      clk,
  input logic      rstn,
  input logic      arvalid,
  input logic      arready,
  input fetch_ar_t ar,
  input logic      rvalid,
  input logic      rready,
  input fetch_r_t  r,
  input logic      instr_valid
);

  // A stalled request may not change.
  a_ar_stable: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && !arready |=> arvalid && $stable(ar))
    else $error("read address changed or dropped while arready was low");

  a_rready_high: assert property (@(posedge clk) disable iff (!rstn) rready)
    else $error("rready went low");

  a_reset_quiet: assert property (@(posedge clk) $rose(rstn) |-> !arvalid)
    else $error("arvalid high in the first cycle after reset");

  a_good_beat: assert property (@(posedge clk) disable iff (!rstn)
    rvalid && (r.rresp == resp_okay) |=> instr_valid)
    else $error("instr_valid missing one cycle after a good beat");

  a_valid_source: assert property (@(posedge clk) disable iff (!rstn)
    instr_valid |-> $past(rvalid && (r.rresp == resp_okay)))
    else $error("instr_valid without a good beat one cycle before");

  a_error_beat: assert property (@(posedge clk) disable iff (!rstn)
    rvalid && (r.rresp != resp_okay) |=> !instr_valid)
    else $error("instr_valid raised after an error beat");

endmodule

bind fetch_decode_top fetch_decode_checker i_fetch_decode_checker (
  .clk         (clk),
  .rstn        (rstn),
  .arvalid     (arvalid),
  .arready     (arready),
  .ar          (ar),
  .rvalid      (rvalid),
  .rready      (rready),
  .r           (r),
  .instr_valid (instr_valid)
);

//--- verif/fetch_decode_monitor.sv
`timescale 1ns/1ps

module fetch_decode_monitor
  import rv_fetch_pkg::*;
#(
  parameter int n = 1
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            arvalid,
  input  logic            arready,
  input  fetch_ar_t       ar,
  input  logic            instr_valid,
  input  logic [xlen-1:0] instr_pc,
  input  dec_ctrl_t       dec,
  input  logic [xlen-1:0] imm,
  input  logic [63:0]     name_tbl [n],
  input  logic [22:0]     key_tbl [n],
  input  logic [xlen-1:0] imm_tbl [n],
  output int              errors,
  output logic            done
);

  logic [xlen-1:0] exp_addr;
  logic [xlen-1:0] fetched [n];
  int              req_cnt;
  int              val_cnt;
  logic            after_rst;
  logic [22:0]     act_key;

  // Unit codes: 1 lgc, 2 wlgc, 3 mlgc, 4 wmlgc, 5 br, 0 none, 7 more than one.
  function automatic logic [22:0] key_of(input dec_ctrl_t d);
    logic [2:0] u;
    logic [4:0] op;
    int         hits;
    u    = 3'd0;
    op   = 5'd0;
    hits = 0;
    if (d.lgc_en) begin
      u  = 3'd1;
      op = {1'b0, d.lgc_op};
      hits++;
    end
    if (d.wlgc_en) begin
      u  = 3'd2;
      op = d.wlgc_op;
      hits++;
    end
    if (d.mlgc_en) begin
      u  = 3'd3;
      op = {2'b0, d.mlgc_op};
      hits++;
    end
    if (d.wmlgc_en) begin
      u  = 3'd4;
      op = {1'b0, d.wmlgc_op};
      hits++;
    end
    if (d.br_en) begin
      u  = 3'd5;
      op = {2'b0, d.br_op};
      hits++;
    end
    if (hits > 1) begin
      u = 3'd7;
    end
    return {d.fmt, d.rs1_en, d.rs2_en, u, op, d.jal_en, d.jalr_en, d.load_en,
            d.load_kind, d.store_en, d.store_kind, d.ebreak};
  endfunction

  initial begin
    errors    = 0;
    exp_addr  = reset_pc;
    req_cnt   = 0;
    val_cnt   = 0;
    after_rst = 1'b0;
  end

  assign done = (val_cnt >= n);

  // Sampled mid-cycle, where all DUT outputs are settled.
  always @(negedge clk) begin
    if (!rstn) begin
      if (arvalid !== 1'b0 || instr_valid !== 1'b0) begin
        $display("arvalid or instr_valid high during reset");
        errors++;
      end
      after_rst = 1'b1;
    end else begin
      if (after_rst && (arvalid !== 1'b0 || instr_valid !== 1'b0)) begin
        $display("arvalid or instr_valid high in the first cycle after reset");
        errors++;
      end
      after_rst = 1'b0;
      if (arvalid && arready) begin
        if (req_cnt >= n) begin
          $display("read request issued past the end of the table");
          errors++;
        end else begin
          if (ar.araddr !== exp_addr) begin
            $display("[FAIL] %0s araddr: expected %h actual %h",
                     name_tbl[req_cnt], exp_addr, ar.araddr);
            errors++;
          end
          if (ar.arport !== ar_port_instr) begin
            $display("[FAIL] %0s arport: expected %h actual %h",
                     name_tbl[req_cnt], ar_port_instr, ar.arport);
            errors++;
          end
          fetched[req_cnt] = exp_addr;
          exp_addr = key_tbl[req_cnt][9] ? exp_addr + imm_tbl[req_cnt] : exp_addr + 64'd4;
          req_cnt++;
        end
      end
      if (instr_valid) begin
        if (val_cnt >= n) begin
          $display("more instr_valid pulses than table entries");
          errors++;
        end else begin
          act_key = key_of(dec);
          if (act_key !== key_tbl[val_cnt]) begin
            $display("[FAIL] %0s decode: expected %h actual %h",
                     name_tbl[val_cnt], key_tbl[val_cnt], act_key);
            errors++;
          end
          if (imm !== imm_tbl[val_cnt]) begin
            $display("[FAIL] %0s imm: expected %h actual %h",
                     name_tbl[val_cnt], imm_tbl[val_cnt], imm);
            errors++;
          end
          if (instr_pc !== fetched[val_cnt]) begin
            $display("[FAIL] %0s instr_pc: expected %h actual %h",
                     name_tbl[val_cnt], fetched[val_cnt], instr_pc);
            errors++;
          end
        end
        val_cnt++;
      end
    end
  end

endmodule

//--- verif/tb_fetch_decode.sv
`timescale 1ns/1ps

module tb_fetch_decode
  import rv_fetch_pkg::*;
;

  localparam int n = 25;

  logic            clk = 1'b0;
  logic            rstn;
  logic            arvalid;
  logic            arready;
  fetch_ar_t       ar;
  logic            rvalid;
  logic            rready;
  fetch_r_t        r;
  logic            instr_valid;
  logic [xlen-1:0] instr_pc;
  dec_ctrl_t       dec;
  logic [xlen-1:0] imm;

  logic [31:0]     word_tbl [n];
  logic            err_tbl [n];
  logic [63:0]     name_tbl [n];
  logic [22:0]     key_tbl [n];
  logic [xlen-1:0] imm_tbl [n];
  int              fill_idx;
  int              errors;
  int              timeouts;
  logic            done;
  logic [31:0]     lfsr_state;

  fetch_decode_top i_fetch_decode_top (
    .clk         (clk),
    .rstn        (rstn),
    .arvalid     (arvalid),
    .arready     (arready),
    .ar          (ar),
    .rvalid      (rvalid),
    .rready      (rready),
    .r           (r),
    .instr_valid (instr_valid),
    .instr_pc    (instr_pc),
    .dec         (dec),
    .imm         (imm)
  );

  fetch_decode_monitor #(.n(n)) i_monitor (
    .clk (clk), .rstn (rstn), .arvalid (arvalid), .arready (arready), .ar (ar),
    .instr_valid (instr_valid), .instr_pc (instr_pc), .dec (dec), .imm (imm),
    .name_tbl (name_tbl), .key_tbl (key_tbl), .imm_tbl (imm_tbl),
    .errors (errors), .done (done)
  );

  always #10 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int nbits, output int val);
    int k;
    val = 0;
    for (k = 0; k < nbits; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = (val << 1) | lfsr_state[0];
    end
  endtask

  task automatic add_test(input logic [63:0] name, input logic [31:0] word, input logic err,
                          input instr_fmt_e fmt, input logic [1:0] rs, input logic [2:0] unit,
                          input logic [4:0] op, input logic [1:0] jmp, input logic [3:0] ld,
                          input logic [2:0] st, input logic eb, input logic [63:0] imm_exp);
    name_tbl[fill_idx] = name;
    word_tbl[fill_idx] = word;
    err_tbl[fill_idx]  = err;
    key_tbl[fill_idx]  = {fmt, rs, unit, op, jmp, ld, st, eb};
    imm_tbl[fill_idx]  = imm_exp;
    fill_idx++;
  endtask

  // Columns: name, word, error first, fmt, rs1/rs2, unit, op, jal/jalr,
  // load en/kind, store en/kind, ebreak, immediate.
  task automatic fill_table();
    fill_idx = 0;
    add_test("lui",   32'h123450B7, 0, fmt_u, 2'b00, 1, 5'h0F, 2'b00, 4'h0, 3'h0, 0, 64'h12345000);
    add_test("auipc", 32'hFFFFF117, 0, fmt_u, 2'b00, 1, 5'h00, 2'b00, 4'h0, 3'h0, 0, -64'sd4096);
    add_test("jal",   32'h010000EF, 0, fmt_j, 2'b00, 1, 5'h00, 2'b10, 4'h0, 3'h0, 0, 64'd16);
    add_test("jalr",  32'h008100E7, 1, fmt_i, 2'b10, 1, 5'h00, 2'b01, 4'h0, 3'h0, 0, 64'd8);
    add_test("bne",   32'hFE2098E3, 0, fmt_b, 2'b11, 5, 5'h01, 2'b00, 4'h0, 3'h0, 0, -64'sd16);
    add_test("lb",    32'hFFC30283, 0, fmt_i, 2'b10, 1, 5'h00, 2'b00, 4'h8, 3'h0, 0, -64'sd4);
    add_test("lh",    32'hFFC31283, 0, fmt_i, 2'b10, 1, 5'h00, 2'b00, 4'h9, 3'h0, 0, -64'sd4);
    add_test("lw",    32'hFFC32283, 0, fmt_i, 2'b10, 1, 5'h00, 2'b00, 4'hA, 3'h0, 0, -64'sd4);
    add_test("ld",    32'hFFC33283, 1, fmt_i, 2'b10, 1, 5'h00, 2'b00, 4'hB, 3'h0, 0, -64'sd4);
    add_test("lbu",   32'hFFC34283, 0, fmt_i, 2'b10, 1, 5'h00, 2'b00, 4'hC, 3'h0, 0, -64'sd4);
    add_test("lhu",   32'hFFC35283, 0, fmt_i, 2'b10, 1, 5'h00, 2'b00, 4'hD, 3'h0, 0, -64'sd4);
    add_test("lwu",   32'hFFC36283, 0, fmt_i, 2'b10, 1, 5'h00, 2'b00, 4'hE, 3'h0, 0, -64'sd4);
    add_test("sb",    32'h00740623, 0, fmt_s, 2'b10, 1, 5'h00, 2'b00, 4'h0, 3'h4, 0, 64'd12);
    add_test("sh",    32'h00741623, 0, fmt_s, 2'b10, 1, 5'h00, 2'b00, 4'h0, 3'h5, 0, 64'd12);
    add_test("sw",    32'h00742623, 0, fmt_s, 2'b10, 1, 5'h00, 2'b00, 4'h0, 3'h6, 0, 64'd12);
    add_test("sd",    32'h00743623, 0, fmt_s, 2'b10, 1, 5'h00, 2'b00, 4'h0, 3'h7, 0, 64'd12);
    add_test("addi",  32'hFFF58513, 0, fmt_i, 2'b10, 1, 5'h00, 2'b00, 4'h0, 3'h0, 0, -64'sd1);
    add_test("srai",  32'h4035D513, 0, fmt_i, 2'b10, 1, 5'h0D, 2'b00, 4'h0, 3'h0, 0, 64'h403);
    add_test("sub",   32'h40E68633, 1, fmt_r, 2'b11, 1, 5'h08, 2'b00, 4'h0, 3'h0, 0, 64'd0);
    add_test("addiw", 32'h0055851B, 0, fmt_i, 2'b10, 2, 5'h10, 2'b00, 4'h0, 3'h0, 0, 64'd5);
    add_test("subw",  32'h40E6863B, 0, fmt_r, 2'b11, 2, 5'h18, 2'b00, 4'h0, 3'h0, 0, 64'd0);
    add_test("mul",   32'h02E68633, 0, fmt_r, 2'b11, 3, 5'h00, 2'b00, 4'h0, 3'h0, 0, 64'd0);
    add_test("divw",  32'h02E6C63B, 0, fmt_r, 2'b11, 4, 5'h0C, 2'b00, 4'h0, 3'h0, 0, 64'd0);
    add_test("j_back", 32'hFF9FF06F, 0, fmt_j, 2'b00, 1, 5'h00, 2'b10, 4'h0, 3'h0, 0, -64'sd8);
    add_test("ebreak", 32'h00100073, 0, fmt_none, 2'b00, 0, 5'h00, 2'b00, 4'h0, 3'h0, 1, 64'd0);
  endtask

  // One table entry per accepted request.
  task automatic serve_entry(input int idx, output bit timed_out);
    int cnt;
    int delay;
    timed_out = 1'b0;
    cnt = 0;
    while (!arvalid && cnt < 200) begin
      @(negedge clk);
      cnt++;
    end
    if (!arvalid) begin
      $display("no read request seen for table entry %0d", idx);
      timed_out = 1'b1;
      return;
    end
    draw_bits(2, delay);
    repeat (delay) @(posedge clk);
    @(posedge clk);
    arready <= 1'b1;
    @(negedge clk);
    @(posedge clk);
    arready <= 1'b0; // Handshake at this edge.
    if (err_tbl[idx]) begin
      draw_bits(2, delay);
      repeat (delay) @(posedge clk);
      @(posedge clk);
      rvalid <= 1'b1;
      r      <= '{rdata: {word_tbl[idx], ~word_tbl[idx]}, rresp: 2'b10};
      @(posedge clk);
      rvalid <= 1'b0;
    end
    draw_bits(2, delay);
    repeat (delay) @(posedge clk);
    @(posedge clk);
    rvalid <= 1'b1;
    r      <= '{rdata: {~word_tbl[idx], word_tbl[idx]}, rresp: resp_okay};
    @(posedge clk);
    rvalid <= 1'b0;
    r      <= '0;
  endtask

  initial begin
    rstn       = 1'b0;
    arready    = 1'b0;
    rvalid     = 1'b0;
    r          = '0;
    timeouts   = 0;
    lfsr_state = 32'ha8532790;
    fill_table();
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
  end

  initial begin : responder
    int  i;
    bit  to;
    repeat (3) @(posedge clk);
    for (i = 0; i < n; i++) begin
      serve_entry(i, to);
      if (to) begin
        timeouts++;
        break;
      end
    end
  end

  initial begin : finish_run
    int cycles;
    cycles = 0;
    while (!done && timeouts == 0 && cycles < 5000) begin
      @(posedge clk);
      cycles++;
    end
    if (!done && timeouts == 0) begin
      $display("timed out waiting for all table entries to decode");
      timeouts++;
    end
    repeat (20) @(posedge clk); // Room for stray pulses.
    $display("check errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
  import rv_fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  input  logic [xlen-1:0] pc,
  output logic            arvalid,
  input  logic            arready,
  output fetch_ar_t       ar,
  input  logic            rvalid,
  output logic            rready,
  input  fetch_r_t        r,
  output logic            ar_fire,
  output logic            beat_ok,
  output logic [ilen-1:0] instr
);

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_exec
  } state_e;

  state_e state;
  state_e state_nxt;

  assign rready  = 1'b1;
  assign ar_fire = arvalid && arready;

  // Error beats are dropped here.
  assign beat_ok = (state == st_exec) && rvalid && rready && (r.rresp == resp_okay);
  assign instr   = beat_ok ? r.rdata[ilen-1:0] : '0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    arvalid   = 1'b0;
    ar        = '0;
    state_nxt = state;
    case (state)
      st_idle: begin
        state_nxt = st_fetch;
      end
      st_fetch: begin
        arvalid   = 1'b1;
        ar.araddr = pc;
        ar.arport = ar_port_instr;
        state_nxt = arready ? st_exec : st_fetch; // Hold until taken.
      end
      st_exec: begin
        if (beat_ok) begin
          // Next request goes out with the beat.
          arvalid   = 1'b1;
          ar.araddr = pc;
          ar.arport = ar_port_instr;
          state_nxt = arready ? st_exec : st_fetch;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

endmodule

//--- verilog/fetch_decode_top.sv
`timescale 1ns/1ps

module fetch_decode_top
  import rv_fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  output logic            arvalid,
  input  logic            arready,
  output fetch_ar_t       ar,
  input  logic            rvalid,
  output logic            rready,
  input  fetch_r_t        r,
  output logic            instr_valid,
  output logic [xlen-1:0] instr_pc,
  output dec_ctrl_t       dec,
  output logic [xlen-1:0] imm
);

  logic [xlen-1:0] pc;
  logic            ar_fire;
  logic            beat_ok;
  logic [ilen-1:0] instr;
  logic [xlen-1:0] imm_raw;

  fetch_ctrl i_fetch_ctrl (
    .clk     (clk),
    .rstn    (rstn),
    .pc      (pc),
    .arvalid (arvalid),
    .arready (arready),
    .ar      (ar),
    .rvalid  (rvalid),
    .rready  (rready),
    .r       (r),
    .ar_fire (ar_fire),
    .beat_ok (beat_ok),
    .instr   (instr)
  );

  pc_unit i_pc_unit (
    .clk     (clk),
    .rstn    (rstn),
    .ar_fire (ar_fire),
    .beat_ok (beat_ok),
    .instr   (instr),
    .imm     (imm_raw),
    .pc      (pc)
  );

  imm_gen i_imm_gen (
    .instr (instr),
    .imm   (imm_raw)
  );

  instr_decoder i_instr_decoder (
    .clk         (clk),
    .rstn        (rstn),
    .beat_ok     (beat_ok),
    .instr       (instr),
    .imm_in      (imm_raw),
    .pc          (pc),
    .instr_valid (instr_valid),
    .instr_pc    (instr_pc),
    .dec         (dec),
    .imm         (imm)
  );

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
  import rv_fetch_pkg::*;
(
  input  logic [ilen-1:0] instr,
  output logic [xlen-1:0] imm
);

  logic [6:0] opcode;
  logic       sign;

  assign opcode = instr[6:0];
  assign sign   = instr[31];

  always_comb begin
    case (opcode)
      op_jalr, op_load, op_imm, op_imm_w: begin
        imm = {{(xlen-12){sign}}, instr[31:20]}; // I, shifts keep funct7 bits.
      end
      op_store: begin
        imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
      end
      op_branch: begin
        imm = {{(xlen-13){sign}}, sign, instr[7], instr[30:25],
               instr[11:8], 1'b0};
      end
      op_lui, op_auipc: begin
        imm = {{(xlen-32){sign}}, instr[31:12], 12'b0};
      end
      op_jal: begin
        imm = {{(xlen-21){sign}}, sign, instr[19:12], instr[20],
               instr[30:21], 1'b0};
      end
      default: begin
        imm = '0; // R type and system.
      end
    endcase
  end

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
  import rv_fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  input  logic            beat_ok,
  input  logic [ilen-1:0] instr,
  input  logic [xlen-1:0] imm_in,
  input  logic [xlen-1:0] pc,
  output logic            instr_valid,
  output logic [xlen-1:0] instr_pc,
  output dec_ctrl_t       dec,
  output logic [xlen-1:0] imm
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            lui_en, auipc_en, jal_en, jalr_en, br_en, load_en, store_en;
  logic            immop_en, immsf_en, wimmop_en, wimmsf_en;
  logic            rsop_en, wrsop_en, mrsop_en, wmrsop_en;
  logic            r_type, i_type, s_type, b_type, u_type, j_type;
  dec_ctrl_t       d;
  logic [xlen-1:0] pc_hold;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign lui_en   = (opcode == op_lui);
  assign auipc_en = (opcode == op_auipc);
  assign jal_en   = (opcode == op_jal);
  assign jalr_en  = (opcode == op_jalr);
  assign br_en    = (opcode == op_branch);
  assign load_en  = (opcode == op_load);
  assign store_en = (opcode == op_store);

  // funct3 x01 marks a shift.
  assign immop_en  = (opcode == op_imm) && (funct3[1:0] != 2'b01);
  assign immsf_en  = (opcode == op_imm) && (funct3[1:0] == 2'b01);
  assign wimmop_en = (opcode == op_imm_w) && (funct3[1:0] != 2'b01);
  assign wimmsf_en = (opcode == op_imm_w) && (funct3[1:0] == 2'b01);
  assign rsop_en   = (opcode == op_reg) && !funct7[0];
  assign wrsop_en  = (opcode == op_reg_w) && !funct7[0];
  assign mrsop_en  = (opcode == op_reg) && funct7[0]; // M extension.
  assign wmrsop_en = (opcode == op_reg_w) && funct7[0];

  assign r_type = rsop_en | wrsop_en | mrsop_en | wmrsop_en;
  assign i_type = jalr_en | load_en | immop_en | immsf_en | wimmop_en | wimmsf_en;
  assign s_type = store_en;
  assign b_type = br_en;
  assign u_type = lui_en | auipc_en;
  assign j_type = jal_en;

  always_comb begin
    d = '0;
    if (r_type) begin
      d.fmt = fmt_r;
    end else if (i_type) begin
      d.fmt = fmt_i;
    end else if (s_type) begin
      d.fmt = fmt_s;
    end else if (b_type) begin
      d.fmt = fmt_b;
    end else if (u_type) begin
      d.fmt = fmt_u;
    end else if (j_type) begin
      d.fmt = fmt_j;
    end else begin
      d.fmt = fmt_none;
    end
    d.rs1_en   = i_type | r_type | s_type | b_type;
    d.rs2_en   = r_type | b_type;
    d.pc_en    = auipc_en | jal_en;
    d.imm_en   = i_type | s_type | u_type | j_type;
    d.lgc_en   = immop_en | rsop_en | immsf_en | auipc_en | lui_en |
                 jalr_en | jal_en | load_en | store_en; // Address adds too.
    d.lgc_op   = ({4{lui_en}} & 4'b1111) |
                 ({4{rsop_en | immsf_en}} & {instr[30], funct3}) |
                 ({4{immop_en}} & {1'b0, funct3});
    d.wlgc_en  = wimmop_en | wimmsf_en | wrsop_en;
    d.wlgc_op  = ({5{wimmop_en}} & {2'b10, funct3}) |
                 ({5{wimmsf_en | wrsop_en}} & {1'b1, instr[30], funct3});
    d.mlgc_en  = mrsop_en;
    d.mlgc_op  = {3{mrsop_en}} & funct3;
    d.wmlgc_en = wmrsop_en;
    d.wmlgc_op = {4{wmrsop_en}} & {1'b1, funct3};
    d.br_en    = br_en;
    d.br_op    = {3{br_en}} & funct3;
    d.jal_en   = jal_en;
    d.jalr_en  = jalr_en;
    d.load_en    = load_en;
    d.load_kind  = {3{load_en}} & funct3;
    d.store_en   = store_en;
    d.store_kind = {2{store_en}} & funct3[1:0];
    d.wb_load  = load_en;
    d.wb_pc    = jal_en | jalr_en; // Link value.
    d.wb_alu   = auipc_en | lui_en | rsop_en | immop_en | immsf_en |
                 wimmop_en | wimmsf_en | wrsop_en | mrsop_en | wmrsop_en;
    d.wb_en    = d.wb_load | d.wb_pc | d.wb_alu;
    d.ebreak   = (opcode == op_system) && (funct7 == 7'b0) && (instr[24:20] == 5'd1);
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      instr_valid <= 1'b0;
      dec         <= '0;
      dec.fmt     <= fmt_none;
    end else begin
      instr_valid <= beat_ok;
      if (beat_ok) begin
        dec <= d;
      end
    end
  end

  // pc already moves on in the beat cycle, so keep the one before.
  always_ff @(posedge clk) begin
    pc_hold <= pc;
    if (beat_ok) begin
      imm      <= imm_in;
      instr_pc <= pc_hold;
    end
  end

endmodule

//--- verilog/pc_unit.sv
`timescale 1ns/1ps

module pc_unit
  import rv_fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rstn,
  input  logic            ar_fire,
  input  logic            beat_ok,
  input  logic [ilen-1:0] instr,
  input  logic [xlen-1:0] imm,
  output logic [xlen-1:0] pc
);

  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] fetch_pc_q;
  logic [xlen-1:0] next_pc;
  logic            is_jal;

  assign is_jal = (instr[6:0] == op_jal);

  // jalr and branches fall through.
  assign next_pc = is_jal ? fetch_pc_q + imm : fetch_pc_q + xlen'(4);
  assign pc      = beat_ok ? next_pc : pc_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pc_q <= reset_pc;
    end else if (beat_ok) begin
      pc_q <= next_pc;
    end
  end

  // Address of the request in flight.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      fetch_pc_q <= pc;
    end
  end

endmodule

//--- verilog/rv_fetch_pkg.sv
package rv_fetch_pkg;

  localparam int xlen = 64;
  localparam int ilen = 32;

  localparam logic [xlen-1:0] reset_pc      = 64'h8000_0000;
  localparam logic [2:0]      ar_port_instr = 3'b100; // Instruction access.
  localparam logic [1:0]      resp_okay     = 2'b00;

  // RV64I/M major opcodes.
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm_w  = 7'b0011011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_reg_w  = 7'b0111011;
  localparam logic [6:0] op_system = 7'b1110011;

  typedef struct packed {
    logic [xlen-1:0] araddr;
    logic [2:0]      arport;
  } fetch_ar_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic [1:0]      rresp;
  } fetch_r_t;

  typedef enum logic [2:0] {
    fmt_r,
    fmt_i,
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j,
    fmt_none
  } instr_fmt_e;

  typedef struct packed {
    instr_fmt_e fmt;
    logic       rs1_en;
    logic       rs2_en;
    logic       pc_en;    // Operand A is the pc.
    logic       imm_en;
    logic       lgc_en;
    logic [3:0] lgc_op;
    logic       wlgc_en;
    logic [4:0] wlgc_op;
    logic       mlgc_en;
    logic [2:0] mlgc_op;
    logic       wmlgc_en;
    logic [3:0] wmlgc_op;
    logic       br_en;
    logic [2:0] br_op;
    logic       jal_en;
    logic       jalr_en;
    logic       load_en;
    logic [2:0] load_kind; // Raw funct3.
    logic       store_en;
    logic [1:0] store_kind;
    logic       wb_en;
    logic       wb_load;
    logic       wb_pc;
    logic       wb_alu;
    logic       ebreak;
  } dec_ctrl_t;

endpackage
